//--- hw/nandCa_defines.svh
`ifndef NAND_CA_DEFINES_SVH
`define NAND_CA_DEFINES_SVH

// number of flash ways sharing the channel, one chip enable each
`define NAND_CA_WAYS 4

// cycles in the chip-select setup window and in every byte window
`define NAND_CA_STEP_CYCLES 10

// write enable asserted this many cycles at the start of a byte window
`define NAND_CA_WE_CYCLES 5

// longest command/address burst
`define NAND_CA_MAX_BYTES 5

`endif

//--- hw/nandCaPkg.sv
`include "nandCa_defines.svh"

package nandCaPkg;

    // one-hot way select, one bit per chip enable
    typedef logic [`NAND_CA_WAYS-1:0] wayMask_t;

    typedef logic [7:0] caByte_t;

    // element 0 sits in the top byte and goes out first
    typedef caByte_t [0:`NAND_CA_MAX_BYTES-1] caData_t;

    // byte on the bus, 0 to max bytes minus one
    typedef logic [2:0] byteIndex_t;

    // cycle count inside one setup or byte window
    typedef logic [3:0] stepTime_t;

    // requested bytes minus one, as seen on iNumOfData
    typedef logic [3:0] byteCount_t;

endpackage

//--- hw/nandCaPinIf.sv
interface nandCaPinIf;
    import nandCaPkg::*;

    logic       capture;    // one cycle, latch the request
    logic       drive;      // pins active, setup through last byte
    byteIndex_t byteIndex;  // byte currently on the bus
    logic       writePhase; // first part of the byte window

    modport seq (
        output capture,
        output drive,
        output byteIndex,
        output writePhase
    );

    modport pins (
        input capture,
        input drive,
        input byteIndex,
        input writePhase
    );

endinterface

//--- hw/nandCaSequencer.sv
`include "nandCa_defines.svh"

module nandCaSequencer (
    input  logic                  iSystemClock,
    input  logic                  iReset,
    input  logic                  iStart,
    input  nandCaPkg::byteCount_t iNumOfData,
    output logic                  oReady,
    output logic                  oLastStep,
    nandCaPinIf.seq               pinBus
);
    import nandCaPkg::*;

    // one-hot state bit positions
    localparam int StReset = 0;
    localparam int StReady = 1;
    localparam int StLatch = 2;
    localparam int StSetup = 3; // chip select setup before the first byte
    localparam int StSend  = 4; // byte windows
    localparam int NumStates = 5;

    logic [NumStates-1:0] state;
    logic [NumStates-1:0] nextState;

    stepTime_t  timeCount;
    byteIndex_t byteCount;
    byteIndex_t lastByte;  // clamped count minus one

    logic timerDone;
    logic lastByteDone;
    logic sending;

    assign timerDone    = (timeCount == stepTime_t'(`NAND_CA_STEP_CYCLES - 1));
    assign lastByteDone = timerDone && (byteCount == lastByte);
    assign sending      = state[StSetup] || state[StSend];

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            state <= NumStates'(1 << StReset);
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = '0;
        case (1'b1)
            state[StReset]: begin
                nextState[StReady] = 1'b1;
            end
            state[StReady]: begin
                // start only counts once oReady is actually up
                if (iStart && oReady) begin
                    nextState[StLatch] = 1'b1;
                end else begin
                    nextState[StReady] = 1'b1;
                end
            end
            state[StLatch]: begin
                nextState[StSetup] = 1'b1;
            end
            state[StSetup]: begin
                if (timerDone) begin
                    nextState[StSend] = 1'b1;
                end else begin
                    nextState[StSetup] = 1'b1;
                end
            end
            state[StSend]: begin
                if (lastByteDone) begin
                    nextState[StReady] = 1'b1;
                end else begin
                    nextState[StSend] = 1'b1;
                end
            end
            default: begin
                nextState[StReady] = 1'b1; // illegal encoding, recover
            end
        endcase
    end

    // byte count, clamped to the burst limit
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            lastByte <= '0;
        end else if (state[StLatch]) begin
            if (iNumOfData >= byteCount_t'(`NAND_CA_MAX_BYTES)) begin
                lastByte <= byteIndex_t'(`NAND_CA_MAX_BYTES - 1);
            end else begin
                lastByte <= byteIndex_t'(iNumOfData);
            end
        end
    end

    // time and byte counters
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            timeCount <= '0;
            byteCount <= '0;
        end else begin
            if (sending && !timerDone) begin
                timeCount <= timeCount + 1'b1;
            end else begin
                timeCount <= '0;
            end

            if (!state[StSend]) begin
                byteCount <= '0;
            end else if (timerDone) begin
                byteCount <= byteCount + 1'b1; // next byte window
            end
        end
    end

    // status outputs line up with the pin register stage
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            oReady    <= 1'b0;
            oLastStep <= 1'b0;
        end else begin
            // pins still drain one cycle after the last send cycle
            oReady    <= nextState[StReady] && !state[StSend];
            oLastStep <= state[StSend] && lastByteDone;
        end
    end

    assign pinBus.capture    = state[StLatch];
    assign pinBus.drive      = sending;
    assign pinBus.byteIndex  = byteCount;
    assign pinBus.writePhase = state[StSend]
                               && (timeCount < stepTime_t'(`NAND_CA_WE_CYCLES));

endmodule

//--- hw/nandCaPinDriver.sv
module nandCaPinDriver (
    input  logic                 iSystemClock,
    input  logic                 iReset,
    input  nandCaPkg::wayMask_t  iTargetWay,
    input  logic                 iCaSelect,
    input  nandCaPkg::caData_t   iCaData,
    nandCaPinIf.pins             pinBus,
    output nandCaPkg::wayMask_t  oChipEnable,
    output logic                 oCommandLatchEnable,
    output logic                 oAddressLatchEnable,
    output logic                 oWriteEnable,
    output nandCaPkg::caByte_t   oDq
);
    import nandCaPkg::*;

    wayMask_t targetWay;
    logic     caSelect;   // high for a command cycle
    caData_t  caData;

    // request held for the whole cycle
    always_ff @(posedge iSystemClock) begin
        if (pinBus.capture) begin
            targetWay <= iTargetWay;
            caSelect  <= iCaSelect;
            caData    <= iCaData;
        end
    end

    // one register stage onto the flash pins
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            oChipEnable         <= '0;
            oCommandLatchEnable <= 1'b0;
            oAddressLatchEnable <= 1'b0;
            oWriteEnable        <= 1'b0;
            oDq                 <= '0;
        end else if (pinBus.drive) begin
            oChipEnable         <= targetWay;
            oCommandLatchEnable <= caSelect;
            oAddressLatchEnable <= !caSelect;
            oWriteEnable        <= pinBus.writePhase;
            // byte 0 already on the bus during setup
            oDq                 <= caData[pinBus.byteIndex];
        end else begin
            oChipEnable         <= '0;
            oCommandLatchEnable <= 1'b0;
            oAddressLatchEnable <= 1'b0;
            oWriteEnable        <= 1'b0;
            oDq                 <= '0;
        end
    end

endmodule

//--- hw/nandCaTop.sv
`include "nandCa_defines.svh"

module nandCaTop (
    input  logic                 iSystemClock,
    input  logic                 iReset,

    // request side
    input  logic                 iStart,
    input  nandCaPkg::wayMask_t  iTargetWay,
    input  nandCaPkg::byteCount_t iNumOfData,
    input  logic                 iCaSelect,
    input  nandCaPkg::caData_t   iCaData,
    output logic                 oReady,
    output logic                 oLastStep,

    // flash pins
    output nandCaPkg::wayMask_t  oChipEnable,
    output logic                 oCommandLatchEnable,
    output logic                 oAddressLatchEnable,
    output logic                 oWriteEnable,
    output nandCaPkg::caByte_t   oDq
);

    nandCaPinIf pinBus ();

    // timing and byte sequencing
    nandCaSequencer sequencer (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iStart       (iStart),
        .iNumOfData   (iNumOfData),
        .oReady       (oReady),
        .oLastStep    (oLastStep),
        .pinBus       (pinBus.seq)
    );

    // request capture and pin registers
    nandCaPinDriver pinDriver (
        .iSystemClock        (iSystemClock),
        .iReset              (iReset),
        .iTargetWay          (iTargetWay),
        .iCaSelect           (iCaSelect),
        .iCaData             (iCaData),
        .pinBus              (pinBus.pins),
        .oChipEnable         (oChipEnable),
        .oCommandLatchEnable (oCommandLatchEnable),
        .oAddressLatchEnable (oAddressLatchEnable),
        .oWriteEnable        (oWriteEnable),
        .oDq                 (oDq)
    );

endmodule

//--- test/tbClockGen.sv
module tbClockGen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    // 20 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    // two rising edges in reset, released just after the second
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

//--- test/nandCaTb.sv
`include "nandCa_defines.svh"

module nandCaTb;
    timeunit 1ns;
    timeprecision 100ps;
    import nandCaPkg::*;

    localparam int Step         = `NAND_CA_STEP_CYCLES;
    localparam int WeCycles     = `NAND_CA_WE_CYCLES;
    localparam int MaxBytes     = `NAND_CA_MAX_BYTES;
    localparam int DataWidth    = 8 * `NAND_CA_MAX_BYTES;
    localparam int CycleTimeout = 4 * Step * (MaxBytes + 1);

    logic       iSystemClock;
    logic       iReset;
    logic       iStart;
    wayMask_t   iTargetWay;
    byteCount_t iNumOfData;
    logic       iCaSelect;
    caData_t    iCaData;
    logic       oReady;
    logic       oLastStep;
    wayMask_t   oChipEnable;
    logic       oCommandLatchEnable;
    logic       oAddressLatchEnable;
    logic       oWriteEnable;
    caByte_t    oDq;

    // cycle currently expected on the pins
    logic                 modelActive;
    int                   modelStart;
    int                   modelBytes;
    wayMask_t             modelMask;
    logic                 modelSel;
    logic [DataWidth-1:0] modelData;

    int   cycle = 0;
    int   sinceReset = 0;
    int   lastStepTotal = 0;
    int   modelErrors = 0;
    int   propErrors = 0;
    int   seqErrors = 0;
    int   testsRun;
    int   testsFailed;
    int   errorsAtStart;
    logic timedOut;

    tbClockGen clockGen (.clock(iSystemClock), .reset(iReset));

    nandCaTop dut (
        .iSystemClock        (iSystemClock),
        .iReset              (iReset),
        .iStart              (iStart),
        .iTargetWay          (iTargetWay),
        .iNumOfData          (iNumOfData),
        .iCaSelect           (iCaSelect),
        .iCaData             (iCaData),
        .oReady              (oReady),
        .oLastStep           (oLastStep),
        .oChipEnable         (oChipEnable),
        .oCommandLatchEnable (oCommandLatchEnable),
        .oAddressLatchEnable (oAddressLatchEnable),
        .oWriteEnable        (oWriteEnable),
        .oDq                 (oDq)
    );

    always @(posedge iSystemClock) begin
        cycle <= cycle + 1;
        sinceReset <= iReset ? 0 : sinceReset + 1;
    end

    lastThenReady: assert property (@(posedge iSystemClock) disable iff (iReset)
        oLastStep |=> oReady)
    else begin
        $display("Mismatch at %0t: oReady not high after oLastStep", $time);
        propErrors++;
    end

    lastSingle: assert property (@(posedge iSystemClock) disable iff (iReset)
        oLastStep |=> !oLastStep)
    else begin
        $display("Mismatch at %0t: oLastStep longer than one cycle", $time);
        propErrors++;
    end

    latchExclusive: assert property (@(posedge iSystemClock) disable iff (iReset)
        !(oCommandLatchEnable && oAddressLatchEnable))
    else begin
        $display("Mismatch at %0t: both latch enables high", $time);
        propErrors++;
    end

    weNeedsCe: assert property (@(posedge iSystemClock) disable iff (iReset)
        oWriteEnable |-> (oChipEnable != '0))
    else begin
        $display("Mismatch at %0t: oWriteEnable without chip enable", $time);
        propErrors++;
    end

    readyIdle: assert property (@(posedge iSystemClock) disable iff (iReset)
        oReady |-> (oChipEnable == '0 && !oWriteEnable))
    else begin
        $display("Mismatch at %0t: pins active while oReady is high", $time);
        propErrors++;
    end

    task automatic reportPin(input string name, input int got, input int exp, input int k);
        $display("Mismatch at %0t: %s is %0h, expected %0h at offset %0d", $time, name, got,
                 exp, k);
        modelErrors++;
    endtask

    // pins compared against the timing model on the falling edge
    always @(negedge iSystemClock) begin : pinCheck
        int       k;
        int       b;
        int       lastK;
        logic     expReady;
        logic     expLast;
        logic     expCle;
        logic     expAle;
        logic     expWe;
        wayMask_t expCe;
        caByte_t  expDq;
        expReady = 1'b1;
        expLast  = 1'b0;
        expCle   = 1'b0;
        expAle   = 1'b0;
        expWe    = 1'b0;
        expCe    = '0;
        expDq    = '0;
        k        = cycle - modelStart;
        lastK    = 1 + Step * (modelBytes + 1);
        if (oLastStep) lastStepTotal++;
        if (iReset || sinceReset == 0) begin
            expReady = 1'b0;
        end else if (modelActive && k >= 0 && k <= lastK) begin
            expReady = 1'b0;
            expLast  = (k == lastK);
            if (k >= 2) begin // pin stage one cycle behind the latch cycle
                expCe  = modelMask;
                expCle = modelSel;
                expAle = !modelSel;
                b      = 0;
                if (k >= 2 + Step) begin
                    b     = (k - 2 - Step) / Step;
                    expWe = ((k - 2 - Step) % Step) < WeCycles;
                end
                expDq = caByte_t'(modelData >> (8 * (MaxBytes - 1 - b))); // msb first
            end
        end
        assert (oReady == expReady) else reportPin("oReady", int'(oReady), int'(expReady), k);
        assert (oLastStep == expLast)
            else reportPin("oLastStep", int'(oLastStep), int'(expLast), k);
        assert (oChipEnable == expCe)
            else reportPin("oChipEnable", int'(oChipEnable), int'(expCe), k);
        assert (oCommandLatchEnable == expCle)
            else reportPin("oCommandLatchEnable", int'(oCommandLatchEnable), int'(expCle), k);
        assert (oAddressLatchEnable == expAle)
            else reportPin("oAddressLatchEnable", int'(oAddressLatchEnable), int'(expAle), k);
        assert (oWriteEnable == expWe)
            else reportPin("oWriteEnable", int'(oWriteEnable), int'(expWe), k);
        assert (oDq == expDq) else reportPin("oDq", int'(oDq), int'(expDq), k);
    end

    function automatic int totalErrors();
        return modelErrors + propErrors + seqErrors;
    endfunction

    function automatic wayMask_t randomWay();
        return wayMask_t'(1 << ($urandom() % `NAND_CA_WAYS));
    endfunction

    function automatic logic [DataWidth-1:0] randomData();
        logic [DataWidth-1:0] data;
        data = '0;
        for (int i = 0; i < MaxBytes; i++) begin
            data = {data[DataWidth-9:0], caByte_t'($urandom())};
        end
        return data;
    endfunction

    task automatic waitReady(output int cycles);
        cycles = 0;
        while (!oReady) begin
            if (cycles >= CycleTimeout) begin
                $display("timeout at %0t: oReady never went high", $time);
                timedOut = 1'b1;
                break;
            end
            @(posedge iSystemClock);
            #2;
            cycles++;
        end
    endtask

    // one request, optionally with a stray iStart pulse while oReady is low
    task automatic runCycle(input wayMask_t mask, input byteCount_t num, input logic sel,
                            input logic [DataWidth-1:0] data, input int extraPulseAt);
        int waited;
        int elapsed;
        int lastBefore;
        int nBytes;
        waitReady(waited);
        if (timedOut) return;
        nBytes = int'(num) + 1;
        if (nBytes > MaxBytes) nBytes = MaxBytes;
        modelMask   = mask;
        modelSel    = sel;
        modelData   = data;
        modelBytes  = nBytes;
        modelStart  = cycle + 1;
        modelActive = 1'b1;
        lastBefore  = lastStepTotal;
        iStart      = 1'b1;
        iTargetWay  = mask;
        iNumOfData  = num;
        iCaSelect   = sel;
        iCaData     = caData_t'(data);
        @(posedge iSystemClock); // start edge
        #2;
        iStart  = 1'b0;
        elapsed = 0;
        while (!oReady) begin
            if (elapsed >= CycleTimeout) begin
                $display("timeout at %0t: cycle did not finish", $time);
                timedOut = 1'b1;
                break;
            end
            @(posedge iSystemClock);
            #2;
            elapsed++;
            if (elapsed == extraPulseAt && !oReady) begin
                iStart     = 1'b1;
                iTargetWay = ~mask;
                iCaSelect  = !sel;
                iCaData    = caData_t'(~data);
            end else begin
                iStart = 1'b0;
            end
        end
        if (timedOut) return;
        assert (elapsed == 2 + Step * (nBytes + 1)) else begin
            $display("Mismatch at %0t: cycle took %0d clocks, expected %0d", $time, elapsed,
                     2 + Step * (nBytes + 1));
            seqErrors++;
        end
        assert (lastStepTotal - lastBefore == 1) else begin
            $display("Mismatch at %0t: %0d oLastStep pulses", $time, lastStepTotal - lastBefore);
            seqErrors++;
        end
    endtask

    task automatic endTest(input string name);
        @(posedge iSystemClock);
        #2;
        testsRun++;
        if (timedOut || totalErrors() != errorsAtStart) begin
            testsFailed++;
            $display("%s: failed", name);
        end else begin
            $display("%s: passed", name);
        end
        errorsAtStart = totalErrors();
    endtask

    task automatic resetState();
        int waited;
        waited = 0;
        @(posedge iSystemClock); // reset is up by the first edge
        #2;
        while (iReset) begin
            if (waited >= 10) begin
                $display("timeout at %0t: reset never released", $time);
                timedOut = 1'b1;
                break;
            end
            @(posedge iSystemClock);
            #2;
            waited++;
        end
        if (timedOut) return;
        assert (!oReady && !oLastStep && oChipEnable == '0 && oDq == '0) else begin
            $display("Mismatch at %0t: outputs not low after reset", $time);
            seqErrors++;
        end
        waitReady(waited);
        assert (waited == 1) else begin
            $display("Mismatch at %0t: oReady rose %0d cycles after reset", $time, waited);
            seqErrors++;
        end
        // second pulse lands in the idle cycle between oLastStep and oReady
        runCycle(randomWay(), 3, 1'b0, randomData(), 1 + Step * 5);
    endtask

    initial begin
        byteCount_t num;
        void'($urandom(32'hb25e));
        iStart        = 1'b0;
        iTargetWay    = '0;
        iNumOfData    = '0;
        iCaSelect     = 1'b0;
        iCaData       = '0;
        modelActive   = 1'b0;
        modelStart    = 0;
        modelBytes    = 1;
        modelMask     = '0;
        modelSel      = 1'b0;
        modelData     = '0;
        testsRun      = 0;
        testsFailed   = 0;
        errorsAtStart = 0;
        timedOut      = 1'b0;

        resetState();
        endTest("resetState");
        if (!timedOut) begin
            runCycle(randomWay(), 4, 1'b0, randomData(), 0);
            endTest("addressCycle");
        end
        if (!timedOut) begin
            runCycle(randomWay(), 0, 1'b1, randomData(), 0);
            endTest("commandCycle");
        end
        if (!timedOut) begin
            for (int w = 0; w < `NAND_CA_WAYS && !timedOut; w++) begin
                runCycle(wayMask_t'(1 << w), 1, 1'(w % 2), randomData(), 0);
            end
            endTest("writeAndChipEnable");
        end
        if (!timedOut) begin
            for (int i = 0; i < 10 && !timedOut; i++) begin
                num = (i < 2) ? byteCount_t'(15 - i) : byteCount_t'($urandom() % 16);
                runCycle(randomWay(), num, 1'($urandom() % 2), randomData(), 0);
            end
            endTest("cycleLength");
        end

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, totalErrors());
        if (totalErrors() == 0 && !timedOut) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- nandCa.f
+incdir+hw
hw/nandCaPkg.sv
hw/nandCaPinIf.sv
hw/nandCaSequencer.sv
hw/nandCaPinDriver.sv
hw/nandCaTop.sv
test/tbClockGen.sv
test/nandCaTb.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/nandCaSim

rm -rf obj_dir "$LOG"

if ! verilator --binary --timing --assert \
        --timescale 1ns/1ps \
        --top-module nandCaTb \
        -f nandCa.f \
        -o nandCaSim; then
    echo "verilator build failed"
    exit 1
fi

if ! "$BIN" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "^TEST PASS$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
